/* design/isaPkg.sv */
package isaPkg;

	localparam int NUM_REGS = 32;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  regIdx_t;

	// Opcodes kept from the full instruction set
	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_LI    = 6'b001001,
		OP_XORI  = 6'b001110,
		OP_LW    = 6'b100011,
		OP_SW    = 6'b101011
	} opcode_t;

	// R-type function codes
	typedef enum logic [5:0] {
		FUNC_ADD = 6'b100000,
		FUNC_SUB = 6'b100010,
		FUNC_SLT = 6'b101010
	} func_t;

	typedef struct packed {
		opcode_t    opcode;
		regIdx_t    rs;
		regIdx_t    rt;
		regIdx_t    rd;
		logic [4:0] sa;
		func_t      func;
	} rType_t;

	typedef struct packed {
		opcode_t     opcode;
		regIdx_t     rs;
		regIdx_t     rt;
		logic [15:0] imm;
	} iType_t;

endpackage

/* design/pipePkg.sv */
package pipePkg;

	import isaPkg::*;

	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;

	typedef logic [$clog2(IMEM_DEPTH)-1:0] imemAddr_t;
	typedef logic [$clog2(DMEM_DEPTH)-1:0] dmemAddr_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_SLT = 3'd2,
		ALU_XOR = 3'd3
	} aluOp_t;

	// Loader port, toData selects data memory
	typedef struct packed {
		logic        valid;
		logic        toData;
		logic [7:0]  address;
		logic [31:0] word;
	} loadWrite_t;

	typedef struct packed {
		logic  valid;
		word_t instr;
	} ifId_t;

	typedef struct packed {
		logic    valid;
		regIdx_t rs;
		regIdx_t rt;
		word_t   opA;
		word_t   opB;
		word_t   imm;
		logic    useImm;
		aluOp_t  aluOp;
		logic    isLoad;
		logic    isStore;
		logic    isLi;
		logic    regWrite;
		regIdx_t dest;
	} idEx_t;

	typedef struct packed {
		logic    valid;
		logic    isLoad;
		logic    isStore;
		logic    regWrite;
		regIdx_t dest;
		word_t   result;
		word_t   storeData;
	} exMem_t;

	// Register write, also the retire port
	typedef struct packed {
		logic       valid;
		logic [4:0] dest;
		word_t      value;
	} regWrite_t;

	typedef struct packed {
		logic      valid;
		dmemAddr_t address;
		word_t     data;
	} memWrite_t;

endpackage

/* design/fetchStage.sv */
`timescale 1ns/1ns

module fetchStage import isaPkg::*, pipePkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  loadWrite_t load,
	output ifId_t      ifId
);

	word_t imem [IMEM_DEPTH];

	// One extra bit so the PC can sit at IMEM_DEPTH
	logic [$clog2(IMEM_DEPTH):0] pc;

	// Program loading
	always_ff @(posedge clk) begin
		if (rst && load.valid && !load.toData) begin
			imem[load.address] <= load.word;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			ifId.valid <= 1'b0;
		end else if (pc < IMEM_DEPTH) begin
			pc <= pc + 1'b1;
			ifId.valid <= 1'b1;
		end else begin
			ifId.valid <= 1'b0;
		end
		ifId.instr <= imem[imemAddr_t'(pc)];
	end

	// Instruction memory is only written by the loader during reset
	assert property (@(posedge clk) (load.valid && !load.toData) |-> rst);

endmodule

/* design/decodeStage.sv */
`timescale 1ns/1ns

module decodeStage import isaPkg::*, pipePkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  ifId_t     ifId,
	input  regWrite_t wbWrite,
	output idEx_t     idEx
);

	word_t   regFile [NUM_REGS];
	rType_t  rInstr;
	iType_t  iInstr;
	word_t   rsVal;
	word_t   rtVal;
	aluOp_t  aluOp;
	logic    useImm;
	logic    isLoad;
	logic    isStore;
	logic    isLi;
	logic    writes;
	regIdx_t dest;

	assign rInstr = rType_t'(ifId.instr);
	assign iInstr = iType_t'(ifId.instr);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regFile[i] <= '0;
			end
		end else if (wbWrite.valid && wbWrite.dest != '0) begin
			regFile[wbWrite.dest] <= wbWrite.value;
		end
	end

	// Writeback bypass, same-cycle write wins
	assign rsVal = (wbWrite.valid && wbWrite.dest == rInstr.rs) ? wbWrite.value
		: regFile[rInstr.rs];
	assign rtVal = (wbWrite.valid && wbWrite.dest == rInstr.rt) ? wbWrite.value
		: regFile[rInstr.rt];

	always_comb begin
		aluOp = ALU_ADD;
		useImm = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		isLi = 1'b0;
		writes = 1'b0;
		dest = rInstr.rd;
		case (rInstr.opcode)
			OP_RTYPE: begin
				case (rInstr.func)
					FUNC_ADD: begin
						aluOp = ALU_ADD;
						writes = 1'b1;
					end
					FUNC_SUB: begin
						aluOp = ALU_SUB;
						writes = 1'b1;
					end
					FUNC_SLT: begin
						aluOp = ALU_SLT;
						writes = 1'b1;
					end
					// All-zero word lands here and retires as a NOP
					default: writes = 1'b0;
				endcase
			end
			OP_XORI: begin
				aluOp = ALU_XOR;
				useImm = 1'b1;
				writes = 1'b1;
				dest = iInstr.rt;
			end
			OP_LI: begin
				isLi = 1'b1;
				useImm = 1'b1;
				writes = 1'b1;
				dest = iInstr.rt;
			end
			OP_LW: begin
				isLoad = 1'b1;
				useImm = 1'b1;
				writes = 1'b1;
				dest = iInstr.rt;
			end
			OP_SW: begin
				isStore = 1'b1;
				useImm = 1'b1;
			end
			default: writes = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			idEx.valid <= 1'b0;
			idEx.regWrite <= 1'b0;
			idEx.isLoad <= 1'b0;
			idEx.isStore <= 1'b0;
		end else begin
			idEx.valid <= ifId.valid;
			idEx.regWrite <= ifId.valid && writes && dest != '0;
			idEx.isLoad <= ifId.valid && isLoad;
			idEx.isStore <= ifId.valid && isStore;
		end
		idEx.rs <= rInstr.rs;
		idEx.rt <= rInstr.rt;
		idEx.opA <= rsVal;
		idEx.opB <= rtVal;
		idEx.imm <= {{16{iInstr.imm[15]}}, iInstr.imm};
		idEx.useImm <= useImm;
		idEx.aluOp <= aluOp;
		idEx.isLi <= isLi;
		idEx.dest <= dest;
	end

	// Writeback never reports register 0
	assert property (@(posedge clk) disable iff (rst) wbWrite.valid |-> wbWrite.dest != '0);

endmodule

/* design/executeStage.sv */
`timescale 1ns/1ns

module executeStage import isaPkg::*, pipePkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  idEx_t     idEx,
	input  regWrite_t wbWrite,
	output exMem_t    exMem
);

	word_t opA;
	word_t rtVal;
	word_t opB;
	word_t aluOut;
	word_t result;

	// Near source first, then writeback, then the decode read
	function automatic word_t forward(regIdx_t src, word_t readVal);
		if (src == '0) begin
			return readVal;
		end
		if (exMem.regWrite && !exMem.isLoad && exMem.dest == src) begin
			return exMem.result;
		end
		if (wbWrite.valid && wbWrite.dest == src) begin
			return wbWrite.value;
		end
		return readVal;
	endfunction

	always_comb begin
		opA = forward(idEx.rs, idEx.opA);
		rtVal = forward(idEx.rt, idEx.opB);
		opB = idEx.useImm ? idEx.imm : rtVal;
	end

	always_comb begin
		case (idEx.aluOp)
			ALU_ADD: aluOut = opA + opB;
			ALU_SUB: aluOut = opA - opB;
			ALU_SLT: aluOut = word_t'($signed(opA) < $signed(opB));
			ALU_XOR: aluOut = opA ^ opB;
			default: aluOut = opA + opB;
		endcase
	end

	// LI passes the immediate straight through
	assign result = idEx.isLi ? idEx.imm : aluOut;

	always_ff @(posedge clk) begin
		if (rst) begin
			exMem.valid <= 1'b0;
			exMem.isLoad <= 1'b0;
			exMem.isStore <= 1'b0;
			exMem.regWrite <= 1'b0;
		end else begin
			exMem.valid <= idEx.valid;
			exMem.isLoad <= idEx.isLoad;
			exMem.isStore <= idEx.isStore;
			exMem.regWrite <= idEx.regWrite;
		end
		exMem.dest <= idEx.dest;
		exMem.result <= result;
		exMem.storeData <= rtVal;
	end

	// Load-use rule, load data only arrives through writeback
	assert property (@(posedge clk) disable iff (rst)
		(idEx.valid && exMem.isLoad && exMem.regWrite) |->
			!(!idEx.isLi && exMem.dest == idEx.rs) &&
			!((!idEx.useImm || idEx.isStore) && exMem.dest == idEx.rt));

endmodule

/* design/memoryStage.sv */
`timescale 1ns/1ns

module memoryStage import isaPkg::*, pipePkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  loadWrite_t load,
	input  exMem_t     exMem,
	output regWrite_t  wbWrite,
	output memWrite_t  store
);

	word_t     dmem [DMEM_DEPTH];
	dmemAddr_t dataAddr;

	assign dataAddr = dmemAddr_t'(exMem.result);

	// Loader fills memory in reset, stores take over afterwards
	always_ff @(posedge clk) begin
		if (rst) begin
			if (load.valid && load.toData) begin
				dmem[load.address] <= load.word;
			end
		end else if (exMem.isStore) begin
			dmem[dataAddr] <= exMem.storeData;
		end
	end

	assign store = '{valid: exMem.isStore, address: dataAddr, data: exMem.storeData};

	always_ff @(posedge clk) begin
		if (rst) begin
			wbWrite.valid <= 1'b0;
		end else begin
			wbWrite.valid <= exMem.regWrite;
		end
		wbWrite.dest <= exMem.dest;
		wbWrite.value <= exMem.isLoad ? dmem[dataAddr] : exMem.result;
	end

	// Addresses past the data memory would alias
	assert property (@(posedge clk) disable iff (rst)
		(exMem.valid && (exMem.isLoad || exMem.isStore)) |->
			exMem.result[$bits(word_t)-1:$bits(dmemAddr_t)] == '0);

endmodule

/* design/cpuTop.sv */
`timescale 1ns/1ns

module cpuTop import pipePkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  loadWrite_t load,
	output regWrite_t  retire,
	output memWrite_t  store
);

	ifId_t     ifId;
	idEx_t     idEx;
	exMem_t    exMem;
	regWrite_t wbWrite;

	fetchStage fetch (
		.clk  (clk),
		.rst  (rst),
		.load (load),
		.ifId (ifId)
	);

	decodeStage decode (
		.clk     (clk),
		.rst     (rst),
		.ifId    (ifId),
		.wbWrite (wbWrite),
		.idEx    (idEx)
	);

	executeStage execute (
		.clk     (clk),
		.rst     (rst),
		.idEx    (idEx),
		.wbWrite (wbWrite),
		.exMem   (exMem)
	);

	memoryStage memory (
		.clk     (clk),
		.rst     (rst),
		.load    (load),
		.exMem   (exMem),
		.wbWrite (wbWrite),
		.store   (store)
	);

	assign retire = wbWrite;

endmodule

/* tests/tbClock.sv */
`timescale 1ns/1ns

module tbClock (
	input  logic holdReset,
	output logic clk,
	output logic rst
);

	int resetCycles;

	initial begin
		clk = 1'b0;
		resetCycles = 0;
		forever #4 clk = ~clk;
	end

	// Reset stays high for 16 cycles after the last request
	always @(posedge clk) begin
		if (holdReset) begin
			resetCycles <= 0;
		end else if (resetCycles < 16) begin
			resetCycles <= resetCycles + 1;
		end
	end

	assign rst = holdReset || resetCycles < 16;

endmodule

/* tests/cpuTb.sv */
`timescale 1ns/1ns

module cpuTb import isaPkg::*, pipePkg::*; ();

	logic       clk;
	logic       rst;
	logic       holdReset;
	loadWrite_t load;
	regWrite_t  retire;
	memWrite_t  store;

	word_t     prog [$];
	word_t     dataWords [DMEM_DEPTH];
	regWrite_t expRetire [$];
	memWrite_t expStore [$];
	int        checks;
	int        mismatches;
	int        failures;

	tbClock clock (.holdReset(holdReset), .clk(clk), .rst(rst));

	cpuTop uut (.clk(clk), .rst(rst), .load(load), .retire(retire), .store(store));

	function automatic logic [15:0] randomImm();
		word_t r;
		r = $urandom;
		return r[15:0];
	endfunction

	task automatic rTypeOp(func_t func, regIdx_t rd, regIdx_t rs, regIdx_t rt);
		rType_t instr;
		instr = '{opcode: OP_RTYPE, rs: rs, rt: rt, rd: rd, sa: 5'd0, func: func};
		prog.push_back(word_t'(instr));
	endtask

	task automatic iTypeOp(opcode_t op, regIdx_t rt, regIdx_t rs, logic [15:0] imm);
		iType_t instr;
		instr = '{opcode: op, rs: rs, rt: rt, imm: imm};
		prog.push_back(word_t'(instr));
	endtask

	// Each word carries its own address
	function automatic word_t dataPattern(int addr);
		logic [7:0] a;
		a = addr[7:0];
		return {a, ~a, a ^ 8'h5A, 8'hC3};
	endfunction

	task automatic clearTest();
		prog.delete();
		expRetire.delete();
		expStore.delete();
		for (int a = 0; a < DMEM_DEPTH; a++) begin
			dataWords[a] = dataPattern(a);
		end
	endtask

	// In-order model of the instruction set
	task automatic runModel();
		word_t     regs [NUM_REGS];
		word_t     mem [DMEM_DEPTH];
		rType_t    r;
		iType_t    i;
		word_t     immExt;
		word_t     value;
		word_t     addr;
		logic      writes;
		regIdx_t   dest;
		memWrite_t st;
		for (int k = 0; k < NUM_REGS; k++) begin
			regs[k] = '0;
		end
		mem = dataWords;
		foreach (prog[n]) begin
			r = rType_t'(prog[n]);
			i = iType_t'(prog[n]);
			immExt = {{16{i.imm[15]}}, i.imm};
			addr = regs[i.rs] + immExt;
			writes = 1'b1;
			dest = i.rt;
			value = '0;
			case (r.opcode)
				OP_RTYPE: begin
					dest = r.rd;
					if (r.func == FUNC_ADD) value = regs[r.rs] + regs[r.rt];
					else if (r.func == FUNC_SUB) value = regs[r.rs] - regs[r.rt];
					else if (r.func == FUNC_SLT)
						value = ($signed(regs[r.rs]) < $signed(regs[r.rt])) ? 32'd1 : 32'd0;
					else writes = 1'b0;
				end
				OP_XORI: value = regs[i.rs] ^ immExt;
				OP_LI: value = immExt;
				OP_LW: value = mem[dmemAddr_t'(addr)];
				OP_SW: begin
					writes = 1'b0;
					mem[dmemAddr_t'(addr)] = regs[i.rt];
					st = '{valid: 1'b1, address: dmemAddr_t'(addr), data: regs[i.rt]};
					expStore.push_back(st);
				end
				default: writes = 1'b0;
			endcase
			if (writes && dest != 5'd0) begin
				regs[dest] = value;
				expRetire.push_back('{valid: 1'b1, dest: dest, value: value});
			end
		end
	endtask

	task automatic checkRetire(regWrite_t got, regWrite_t want);
		checks++;
		if (got.dest !== want.dest || got.value !== want.value) begin
			$display("mismatch at %0t: retire got r%0d=%h expected r%0d=%h",
				$time, got.dest, got.value, want.dest, want.value);
			mismatches++;
		end
	endtask

	task automatic checkStore(memWrite_t got, memWrite_t want);
		checks++;
		if (got.address !== want.address || got.data !== want.data) begin
			$display("mismatch at %0t: store got [%h]=%h expected [%h]=%h",
				$time, got.address, got.data, want.address, want.data);
			mismatches++;
		end
	endtask

	// Program first, then data memory, all under reset
	task automatic loadMemories();
		word_t w;
		@(posedge clk);
		holdReset <= 1'b1;
		for (int a = 0; a < IMEM_DEPTH + DMEM_DEPTH; a++) begin
			if (a >= IMEM_DEPTH) w = dataWords[a - IMEM_DEPTH];
			else if (a < prog.size()) w = prog[a];
			else w = '0;
			@(posedge clk);
			load <= '{valid: 1'b1, toData: a >= IMEM_DEPTH, address: 8'(a), word: w};
			@(negedge clk);
			if (retire.valid || store.valid) begin
				$display("Retire or store went valid during reset at %0t", $time);
				failures++;
			end
		end
		@(posedge clk);
		load <= '0;
		holdReset <= 1'b0;
	endtask

	task automatic waitResetRelease();
		int cycles;
		cycles = 0;
		while (rst && cycles < 64) begin
			@(negedge clk);
			cycles++;
		end
		if (rst) begin
			$display("Timed out waiting for reset to be released");
			failures++;
		end
	endtask

	task automatic quietCheck(int cycles);
		for (int c = 0; c < cycles; c++) begin
			@(negedge clk);
			if (retire.valid || store.valid) begin
				$display("Unexpected retire or store at %0t", $time);
				failures++;
			end
		end
	endtask

	task automatic collectEvents(int limit);
		int cycles;
		cycles = 0;
		while ((expRetire.size() > 0 || expStore.size() > 0) && cycles < limit) begin
			@(negedge clk);
			cycles++;
			if (retire.valid && expRetire.size() == 0) begin
				$display("Unexpected retire of r%0d at %0t", retire.dest, $time);
				failures++;
			end else if (retire.valid) begin
				checkRetire(retire, expRetire.pop_front());
			end
			if (store.valid && expStore.size() == 0) begin
				$display("Unexpected store at %0t", $time);
				failures++;
			end else if (store.valid) begin
				checkStore(store, expStore.pop_front());
			end
		end
		if (expRetire.size() > 0 || expStore.size() > 0) begin
			$display("Timed out with %0d retires and %0d stores missing",
				expRetire.size(), expStore.size());
			failures++;
		end
		quietCheck(8);
	endtask

	task automatic runProgram();
		runModel();
		loadMemories();
		waitResetRelease();
		collectEvents(IMEM_DEPTH + 16);
	endtask

	task automatic resetIdleTest();
		clearTest();
		loadMemories();
		waitResetRelease();
		quietCheck(IMEM_DEPTH + 8);
	endtask

	// Distances 1, 2 and 3 hit near, far and decode bypass
	task automatic arithmeticChainTest();
		clearTest();
		for (int round = 0; round < 3; round++) begin
			iTypeOp(OP_LI, 5'd1, 5'd0, randomImm());
			iTypeOp(OP_LI, 5'd2, 5'd0, randomImm());
			iTypeOp(OP_LI, 5'd3, 5'd0, randomImm());
			rTypeOp(FUNC_ADD, 5'd4, 5'd1, 5'd2);
			rTypeOp(FUNC_SUB, 5'd5, 5'd4, 5'd3);
			rTypeOp(FUNC_SLT, 5'd6, 5'd5, 5'd4);
			iTypeOp(OP_XORI, 5'd7, 5'd6, randomImm());
			rTypeOp(FUNC_ADD, 5'd8, 5'd7, 5'd5);
			rTypeOp(FUNC_SLT, 5'd9, 5'd1, 5'd8);
			rTypeOp(FUNC_SUB, 5'd10, 5'd9, 5'd6);
			iTypeOp(OP_XORI, 5'd11, 5'd4, randomImm());
			rTypeOp(FUNC_ADD, 5'd12, 5'd11, 5'd11);
			prog.push_back('0);
		end
		runProgram();
	endtask

	task automatic storeLoadTest();
		clearTest();
		for (int round = 0; round < 2; round++) begin
			iTypeOp(OP_LI, 5'd1, 5'd0, 16'(1 + $urandom % 240));
			iTypeOp(OP_LI, 5'd2, 5'd0, randomImm());
			iTypeOp(OP_LI, 5'd3, 5'd0, randomImm());
			iTypeOp(OP_SW, 5'd2, 5'd1, 16'd0);
			iTypeOp(OP_SW, 5'd3, 5'd1, 16'd5);
			iTypeOp(OP_SW, 5'd2, 5'd1, 16'hFFFF);
			iTypeOp(OP_LW, 5'd4, 5'd1, 16'd0);
			iTypeOp(OP_LW, 5'd5, 5'd1, 16'd5);
			iTypeOp(OP_LW, 5'd6, 5'd1, 16'hFFFF);
			rTypeOp(FUNC_ADD, 5'd7, 5'd4, 5'd5);
			rTypeOp(FUNC_SUB, 5'd8, 5'd6, 5'd4);
			iTypeOp(OP_SW, 5'd7, 5'd1, 16'd9);
			iTypeOp(OP_SW, 5'd8, 5'd1, 16'd10);
			iTypeOp(OP_LW, 5'd9, 5'd1, 16'd9);
			iTypeOp(OP_LW, 5'd10, 5'd1, 16'd10);
		end
		runProgram();
	endtask

	task automatic preloadedLoadTest();
		int a;
		int b;
		clearTest();
		a = $urandom % 200;
		b = a + 1 + $urandom % 50;
		dataWords[a] = $urandom;
		dataWords[b] = $urandom;
		iTypeOp(OP_LI, 5'd1, 5'd0, 16'(a));
		iTypeOp(OP_LW, 5'd2, 5'd1, 16'd0);
		iTypeOp(OP_LI, 5'd3, 5'd0, randomImm());
		rTypeOp(FUNC_ADD, 5'd4, 5'd2, 5'd3);
		iTypeOp(OP_LW, 5'd5, 5'd1, 16'(b - a));
		iTypeOp(OP_XORI, 5'd6, 5'd1, randomImm());
		rTypeOp(FUNC_ADD, 5'd7, 5'd5, 5'd2);
		iTypeOp(OP_LW, 5'd8, 5'd0, 16'(a));
		rTypeOp(FUNC_SUB, 5'd9, 5'd1, 5'd3);
		rTypeOp(FUNC_SLT, 5'd10, 5'd8, 5'd7);
		runProgram();
	endtask

	task automatic registerZeroTest();
		clearTest();
		iTypeOp(OP_LI, 5'd1, 5'd0, randomImm());
		iTypeOp(OP_LI, 5'd0, 5'd0, 16'h1234);
		rTypeOp(FUNC_ADD, 5'd0, 5'd1, 5'd1);
		iTypeOp(OP_XORI, 5'd0, 5'd1, 16'h00FF);
		rTypeOp(FUNC_ADD, 5'd2, 5'd0, 5'd1);
		iTypeOp(OP_LI, 5'd0, 5'd0, 16'd5);
		rTypeOp(FUNC_SUB, 5'd3, 5'd1, 5'd0);
		rTypeOp(FUNC_ADD, 5'd4, 5'd0, 5'd0);
		iTypeOp(OP_LW, 5'd0, 5'd0, 16'd0);
		rTypeOp(FUNC_SLT, 5'd5, 5'd0, 5'd1);
		iTypeOp(OP_SW, 5'd1, 5'd0, 16'd3);
		iTypeOp(OP_LW, 5'd6, 5'd0, 16'd3);
		runProgram();
	endtask

	initial begin
		#100000;
		$display("Simulation watchdog expired");
		$display("Regression failed");
		$finish;
	end

	initial begin
		load = '0;
		holdReset = 1'b0;
		checks = 0;
		mismatches = 0;
		failures = 0;
		void'($urandom(77));
		resetIdleTest();
		arithmeticChainTest();
		storeLoadTest();
		preloadedLoadTest();
		registerZeroTest();
		$display("Checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* pipeCpu.f */
design/isaPkg.sv
design/pipePkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/cpuTop.sv
tests/tbClock.sv
tests/cpuTb.sv

/* Makefile */
TOP = cpuTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f pipeCpu.f --Mdir obj_dir -o $(TOP)

run: compile
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
